/* common/arm_isa_pkg.sv */
`include "issue_settings.svh"

package arm_isa_pkg;

	typedef logic [`ISSUE_NUM_REGS-1:0] reg_mask_t; // One bit per register.

	typedef enum logic [3:0] {
		COND_EQ = 4'h0, COND_NE, COND_CS, COND_CC,
		COND_MI, COND_PL, COND_VS, COND_VC,
		COND_HI, COND_LS, COND_GE, COND_LT,
		COND_GT, COND_LE, COND_AL, COND_NV
	} cond_e;

	typedef enum logic [3:0] {
		ALU_AND = 4'h0, ALU_EOR, ALU_SUB, ALU_RSB,
		ALU_ADD, ALU_ADC, ALU_SBC, ALU_RSC,
		ALU_TST, ALU_TEQ, ALU_CMP, ALU_CMN,
		ALU_ORR, ALU_MOV, ALU_BIC, ALU_MVN
	} alu_op_e;

	// Shift types that matter to the carry check.
	localparam logic [1:0] SHIFT_LSL = 2'd0;
	localparam logic [1:0] SHIFT_ROR = 2'd3;

	localparam int CPSR_N = 31;
	localparam int CPSR_Z = 30;
	localparam int CPSR_C = 29;
	localparam int CPSR_V = 28;

	// Data processing and single transfer layout.
	typedef struct packed {
		cond_e      cond;
		logic [1:0] cls;    // Bits 27:26.
		logic       i;      // Immediate operand, or register offset for transfers.
		alu_op_e    opcode;
		logic       s;      // Set flags, or load for transfers.
		logic [3:0] rn;
		logic [3:0] rd;
		logic [3:0] rs;
		logic [3:0] shift;  // Bit 4 selects a shift by register.
		logic [3:0] rm;
	} dp_fields_t;

	// Multiply layout, where rd and rn trade places.
	typedef struct packed {
		cond_e      cond;
		logic [5:0] fixed_hi;
		logic       acc;
		logic       s;
		logic [3:0] rd;
		logic [3:0] rn;
		logic [3:0] rs;
		logic [3:0] fixed_lo; // Always 4'b1001.
		logic [3:0] rm;
	} mul_fields_t;

	typedef union packed {
		dp_fields_t  dp;
		mul_fields_t mul;
	} insn_u;

endpackage

/* common/issue_pkg.sv */
`include "issue_settings.svh"

package issue_pkg;

	// One pipeline slot as it moves between stages.
	typedef struct packed {
		logic        bubble;
		logic [31:0] pc;
		logic [31:0] insn;
	} slot_t;

	// Registers and flags one instruction reads and writes.
	typedef struct packed {
		logic                       use_cpsr;
		logic [`ISSUE_NUM_REGS-1:0] use_regs;
		logic                       def_cpsr;
		logic [`ISSUE_NUM_REGS-1:0] def_regs;
	} deps_t;

	// A write still in flight downstream.
	typedef struct packed {
		logic                       cpsr;
		logic [`ISSUE_NUM_REGS-1:0] regs;
	} wr_entry_t;

endpackage

/* common/issue_settings.svh */
`ifndef ISSUE_SETTINGS_SVH
`define ISSUE_SETTINGS_SVH

// Width of every register mask, one bit per architectural register.
`define ISSUE_NUM_REGS 16

`define ISSUE_LR 14 // Written by a branch with link.

// Stages a result spends in flight before forwarding can supply it.
`define ISSUE_SB_DEPTH 2

`endif

/* dv/issue_tb.sv */
`timescale 1ns/10ps
`include "issue_settings.svh"

module issue_tb;

	logic             clk;
	logic             Nrst;
	issue_pkg::slot_t slot_in;
	issue_pkg::slot_t slot_out;
	issue_pkg::slot_t seen;      // slot_out sampled just after a slot was consumed.
	logic [31:0]      cpsr;
	logic             stall_in;
	logic             flush;
	logic             stall_out;
	int               stalls;    // Stall cycles seen before the last slot was taken.
	int               base;

	tb_clkgen tb_clkgen_inst (
		.clk  (clk),
		.Nrst (Nrst)
	);

	issue_top issue_top_inst (
		.clk       (clk),
		.Nrst      (Nrst),
		.slot_in   (slot_in),
		.cpsr      (cpsr),
		.stall_in  (stall_in),
		.flush     (flush),
		.stall_out (stall_out),
		.slot_out  (slot_out)
	);

	function automatic logic [3:0] reg_at(input int k);
		return 4'((base + k) % 14); // Distinct for small k and never r14 or r15.
	endfunction

	function automatic logic [31:0] add_imm(input logic [3:0] cond, input logic s,
		input logic [3:0] rn, input logic [3:0] rd);
		return {cond, 3'b001, 4'h4, s, rn, rd, 12'h001}; // ADD rd, rn, #1.
	endfunction

	function automatic logic [31:0] add_lsl0(input logic [3:0] rn, input logic [3:0] rd);
		return {4'hE, 3'b000, 4'h4, 1'b0, rn, rd, 8'h00, rn}; // LSL #0 takes in the carry.
	endfunction

	function automatic logic [31:0] mul_insn(input logic [3:0] rd, input logic [3:0] rs);
		return {4'hE, 8'h00, rd, 4'h0, rs, 4'b1001, rs};
	endfunction

	function automatic logic [31:0] ldm_insn(input logic [3:0] rn, input logic [15:0] list);
		return {4'hE, 3'b100, 5'b01001, rn, list}; // LDMIA without writeback.
	endfunction

	task automatic check_value(input string name, input logic [64:0] expected,
		input logic [64:0] actual);
		if (expected !== actual)
		begin
			$display("CHECK FAILED %s: expected %0h, actual %0h", name, expected, actual);
			$display("Test failed");
			$fatal(1);
		end
	endtask

	task automatic report_stuck(input string what);
		$display("Timeout: %s", what);
		$display("Test failed");
		$fatal(1);
	endtask

	// Called on a falling edge; returns on the first falling edge with stall_out low.
	task automatic wait_issue();
		stalls = 0;
		while (stall_out !== 1'b0)
		begin
			if (stalls == 50)
				report_stuck("stall_out stayed high for 50 cycles");
			else
			begin
				stalls++;
				@(negedge clk);
			end
		end
	endtask

	task automatic send(input logic [31:0] pc, input logic [31:0] insn);
		@(posedge clk);
		slot_in <= '{bubble: 1'b0, pc: pc, insn: insn};
		@(negedge clk);
		seen = slot_out;
		wait_issue();
	endtask

	task automatic retire();
		@(posedge clk);
		slot_in <= '{bubble: 1'b1, pc: 32'h0, insn: 32'h0};
		flush   <= 1'b0;
		@(negedge clk);
		seen = slot_out;
		repeat (`ISSUE_SB_DEPTH)
			@(posedge clk); // Lets every recorded write age out.
	endtask

	task automatic hazard_pair(input string name, input logic [31:0] prod,
		input logic [31:0] cons, input int exp_stalls);
		send(32'h100, prod);
		check_value({name, " producer stalls"}, 0, stalls);
		send(32'h104, cons);
		check_value({name, " producer"}, {1'b0, 32'h100, prod}, seen);
		check_value({name, " stalls"}, exp_stalls, stalls);
		retire();
		check_value({name, " consumer"}, {1'b0, 32'h104, cons}, seen);
	endtask

	task automatic cond_case(input logic [3:0] cond, input logic [3:0] nzcv,
		input logic pass);
		logic [31:0] insn;
		string       name;
		name = $sformatf("cond %0d nzcv %b", cond, nzcv);
		insn = add_imm(cond, 1'b0, reg_at(1), reg_at(0));
		@(posedge clk);
		cpsr <= {nzcv, 28'h0};
		send(32'h300, insn);
		check_value(name, 0, stalls);
		send(32'h304, add_imm(4'hE, 1'b0, reg_at(0), reg_at(2)));
		check_value(name, {!pass, 32'h300, insn}, seen);
		check_value({name, " reader"}, pass ? `ISSUE_SB_DEPTH : 0, stalls);
		retire();
	endtask

	task automatic reset_and_flow();
		logic [31:0] insn;
		logic [31:0] prev;
		int          waited;
		waited = 0;
		while (Nrst !== 1'b1)
		begin
			if (waited == 20)
				report_stuck("reset was never released");
			else
			begin
				waited++;
				@(posedge clk);
			end
		end
		@(negedge clk);
		check_value("reset slot_out", {1'b1, 64'h0}, slot_out);
		check_value("reset stall_out", 0, stall_out);
		for (int k = 0; k < 4; k++)
		begin
			insn = add_imm(4'hE, 1'b0, reg_at(7 + k), reg_at(k));
			send(32'h200 + 4 * k, insn);
			check_value("flow stalls", 0, stalls);
			if (k > 0)
				check_value("flow", {1'b0, 32'h1FC + 4 * k, prev}, seen);
			prev = insn;
		end
		retire();
		check_value("flow last", {1'b0, 32'h20C, prev}, seen);
	endtask

	task automatic reg_hazards();
		hazard_pair("add", add_imm(4'hE, 1'b0, reg_at(1), reg_at(0)),
			add_imm(4'hE, 1'b0, reg_at(0), reg_at(2)), `ISSUE_SB_DEPTH);
		hazard_pair("mul", mul_insn(reg_at(0), reg_at(1)),
			add_imm(4'hE, 1'b0, reg_at(0), reg_at(2)), `ISSUE_SB_DEPTH);
		hazard_pair("ldm", ldm_insn(reg_at(1), 16'h0001 << reg_at(0)),
			add_imm(4'hE, 1'b0, reg_at(0), reg_at(2)), `ISSUE_SB_DEPTH);
		hazard_pair("bl", 32'hEB00_0010,
			add_imm(4'hE, 1'b0, 4'(`ISSUE_LR), reg_at(2)), `ISSUE_SB_DEPTH);
		hazard_pair("r15", ldm_insn(reg_at(1), 16'h8000 | (16'h0001 << reg_at(0))),
			add_imm(4'hE, 1'b0, 4'd15, reg_at(2)), 0);
	endtask

	task automatic flag_hazard();
		@(posedge clk);
		cpsr <= 32'h4000_0000; // Z set, so EQ passes.
		hazard_pair("flags eq", add_imm(4'hE, 1'b1, reg_at(1), reg_at(0)),
			add_imm(4'h0, 1'b0, reg_at(2), reg_at(3)), `ISSUE_SB_DEPTH);
		hazard_pair("flags al", add_imm(4'hE, 1'b1, reg_at(1), reg_at(0)),
			add_imm(4'hE, 1'b0, reg_at(2), reg_at(3)), 0);
		hazard_pair("flags lsl0", add_imm(4'hE, 1'b1, reg_at(1), reg_at(0)),
			add_lsl0(reg_at(2), reg_at(3)), `ISSUE_SB_DEPTH);
	endtask

	task automatic condition_codes();
		logic [3:0] pass_nzcv [16];
		logic [3:0] fail_nzcv [16];
		// One NZCV value per condition that passes, and one that fails.
		pass_nzcv = '{4'h4, 4'h0, 4'h2, 4'h0, 4'h8, 4'h0, 4'h1, 4'h0,
			4'h2, 4'h6, 4'h9, 4'h8, 4'h0, 4'h4, 4'h0, 4'h0};
		fail_nzcv = '{4'h0, 4'h4, 4'h0, 4'h2, 4'h0, 4'h8, 4'h0, 4'h1,
			4'h6, 4'h2, 4'h8, 4'h9, 4'h4, 4'h0, 4'h0, 4'hF};
		for (int c = 0; c < 16; c++)
		begin
			if (c != 15)
				cond_case(4'(c), pass_nzcv[c], 1'b1); // NV never passes.
			if (c != 14)
				cond_case(4'(c), fail_nzcv[c], 1'b0); // AL never fails.
		end
	endtask

	task automatic backpressure();
		logic [31:0] prod;
		logic [31:0] cons;
		prod = add_imm(4'hE, 1'b0, reg_at(1), reg_at(0));
		cons = add_imm(4'hE, 1'b0, reg_at(0), reg_at(2));
		send(32'h400, prod);
		@(posedge clk);
		slot_in  <= '{bubble: 1'b0, pc: 32'h404, insn: cons};
		stall_in <= 1'b1; // The producer stays in stage 2a.
		repeat (3)
		begin
			@(negedge clk);
			check_value("hold stall_out", 1, stall_out);
			check_value("hold slot_out", {1'b0, 32'h400, prod}, slot_out);
		end
		@(posedge clk);
		stall_in <= 1'b0;
		@(negedge clk);
		wait_issue();
		check_value("hold window", `ISSUE_SB_DEPTH, stalls);
		retire();
		check_value("hold consumer", {1'b0, 32'h404, cons}, seen);
	endtask

	task automatic flush_cases();
		logic [31:0] prod;
		logic [31:0] cons;
		prod = add_imm(4'hE, 1'b0, reg_at(1), reg_at(0));
		cons = add_imm(4'hE, 1'b0, reg_at(0), reg_at(2));
		@(posedge clk);
		flush <= 1'b1;
		send(32'h500, prod);
		retire();
		check_value("flush now", {1'b1, 32'h500, prod}, seen);
		send(32'h504, cons); // The killed producer left no write behind.
		check_value("flush no record", 0, stalls);
		retire();
		send(32'h508, prod);
		@(posedge clk);
		slot_in <= '{bubble: 1'b0, pc: 32'h50C, insn: cons};
		@(negedge clk);
		check_value("flush hazard", 1, stall_out);
		@(posedge clk);
		flush <= 1'b1;
		retire();
		check_value("flush in stall", {1'b1, 32'h50C, cons}, seen);
		send(32'h510, cons);
		retire();
		check_value("after flush", {1'b0, 32'h510, cons}, seen);
		@(posedge clk);
		stall_in <= 1'b1;
		flush    <= 1'b1;
		slot_in  <= '{bubble: 1'b0, pc: 32'h514, insn: prod};
		@(posedge clk);
		flush <= 1'b0;
		@(posedge clk);
		stall_in <= 1'b0;
		@(negedge clk);
		wait_issue();
		retire();
		check_value("delayed flush", {1'b1, 32'h514, prod}, seen);
		send(32'h518, prod);
		retire();
		check_value("after delayed flush", {1'b0, 32'h518, prod}, seen);
	endtask

	initial
	begin
		slot_in  = '{bubble: 1'b1, pc: 32'h0, insn: 32'h0};
		cpsr     = 32'h0;
		stall_in = 1'b0;
		flush    = 1'b0;
		void'($urandom(44945));
		base = $urandom_range(13, 0);
		reset_and_flow();
		reg_hazards();
		flag_hazard();
		condition_codes();
		backpressure();
		flush_cases();
		$display("Test completed successfully");
		$finish;
	end

endmodule

/* dv/tb_clkgen.sv */
`timescale 1ns/10ps

module tb_clkgen (
	output logic clk,
	output logic Nrst
);

	initial
	begin
		clk = 1'b0;
		forever
			#5 clk = !clk; // 10 ns period.
	end

	initial
	begin
		Nrst = 1'b0;
		repeat (5)
			@(posedge clk);
		Nrst <= 1'b1; // Released after five rising edges.
	end

endmodule

/* hdl/issue_top.sv */
`timescale 1ns/10ps
`include "issue_settings.svh"

module issue_top (
	input  logic             clk,
	input  logic             Nrst,
	input  issue_pkg::slot_t slot_in,
	input  logic [31:0]      cpsr,
	input  logic             stall_in,
	input  logic             flush,
	output logic             stall_out,
	output issue_pkg::slot_t slot_out
);

	arm_isa_pkg::insn_u in_word;
	issue_pkg::deps_t   deps;
	logic               cond_met;
	logic               waiting;
	logic               fire;

	assign in_word = slot_in.insn;

	insn_deps insn_deps_inst (
		.insn (slot_in.insn),
		.deps (deps)
	);

	cond_eval cond_eval_inst (
		.cond     (in_word.dp.cond),
		.cpsr     (cpsr),
		.cond_met (cond_met)
	);

	issue_scoreboard #(
		.DEPTH (`ISSUE_SB_DEPTH)
	) issue_scoreboard_inst (
		.clk      (clk),
		.Nrst     (Nrst),
		.deps     (deps),
		.stall_in (stall_in),
		.fire     (fire),
		.waiting  (waiting)
	);

	issue_stage issue_stage_inst (
		.clk       (clk),
		.Nrst      (Nrst),
		.slot_in   (slot_in),
		.stall_in  (stall_in),
		.flush     (flush),
		.waiting   (waiting),
		.cond_met  (cond_met),
		.stall_out (stall_out),
		.slot_out  (slot_out),
		.fire      (fire)
	);

endmodule

/* issue/cond_eval.sv */
`timescale 1ns/10ps

module cond_eval (
	input  arm_isa_pkg::cond_e cond,
	input  logic [31:0]        cpsr,
	output logic               cond_met
);

	logic n, z, c, v;

	assign n = cpsr[arm_isa_pkg::CPSR_N];
	assign z = cpsr[arm_isa_pkg::CPSR_Z];
	assign c = cpsr[arm_isa_pkg::CPSR_C];
	assign v = cpsr[arm_isa_pkg::CPSR_V];

	always_comb
	begin
		case (cond)
			arm_isa_pkg::COND_EQ: cond_met = z;
			arm_isa_pkg::COND_NE: cond_met = !z;
			arm_isa_pkg::COND_CS: cond_met = c;
			arm_isa_pkg::COND_CC: cond_met = !c;
			arm_isa_pkg::COND_MI: cond_met = n;
			arm_isa_pkg::COND_PL: cond_met = !n;
			arm_isa_pkg::COND_VS: cond_met = v;
			arm_isa_pkg::COND_VC: cond_met = !v;
			arm_isa_pkg::COND_HI: cond_met = c && !z;
			arm_isa_pkg::COND_LS: cond_met = !c || z;
			arm_isa_pkg::COND_GE: cond_met = (n == v);
			arm_isa_pkg::COND_LT: cond_met = (n != v);
			arm_isa_pkg::COND_GT: cond_met = !z && (n == v);
			arm_isa_pkg::COND_LE: cond_met = z || (n != v);
			arm_isa_pkg::COND_AL: cond_met = 1'b1;
			default:              cond_met = 1'b0; // NV never passes.
		endcase
	end

endmodule

/* issue/insn_deps.sv */
`timescale 1ns/10ps
`include "issue_settings.svh"

module insn_deps (
	input  logic [31:0]      insn,
	output issue_pkg::deps_t deps
);

	arm_isa_pkg::insn_u iu;
	logic               cond_matters;
	logic [4:0]         shamt;
	logic               carry_shift;
	logic               load;
	logic               wback;

	function automatic arm_isa_pkg::reg_mask_t idxbit(input logic [3:0] r);
		arm_isa_pkg::reg_mask_t m;
		m = '0;
		if (r != 4'd15) // The PC is never tracked.
			m[r] = 1'b1;
		return m;
	endfunction

	assign iu           = insn;
	assign cond_matters = (iu.dp.cond != arm_isa_pkg::COND_AL);
	assign shamt        = {iu.dp.rs, iu.dp.shift[3]}; // Immediate shift amount in bits 11:7.
	assign load         = iu.dp.s;
	assign wback        = !insn[24] || insn[21]; // Post-index or writeback updates rn.

	// LSL #0 and ROR #0 (RRX) on a register operand both pull in the carry.
	assign carry_shift = !iu.dp.i && !iu.dp.shift[0] && (shamt == 5'd0) &&
		((iu.dp.shift[2:1] == arm_isa_pkg::SHIFT_LSL) ||
		 (iu.dp.shift[2:1] == arm_isa_pkg::SHIFT_ROR));

	always_comb
	begin
		deps          = '0;
		deps.use_cpsr = cond_matters;
		casez (insn)
			32'b????_0000_00??_????_????_????_1001_????: // Multiply is matched ahead of the ALU.
			begin
				deps.use_regs = idxbit(iu.mul.rs) | idxbit(iu.mul.rm) |
					(iu.mul.acc ? idxbit(iu.mul.rn) : '0);
				deps.def_cpsr = iu.mul.s;
				deps.def_regs = idxbit(iu.mul.rd);
			end
			32'b????_0001_0?00_1111_????_0000_0000_0000: // MRS.
			begin
				deps.use_cpsr = cond_matters || !insn[22]; // Reading CPSR rather than SPSR.
				deps.def_regs = idxbit(iu.dp.rd);
			end
			32'b????_0001_0?10_1001_1111_0000_0000_????: // MSR.
			begin
				deps.use_regs = idxbit(iu.dp.rm);
				deps.def_cpsr = 1'b1;
			end
			32'b????_00?1_0?10_1000_1111_????_????_????: // MSR of the flag bits only.
			begin
				deps.use_regs = iu.dp.i ? '0 : idxbit(iu.dp.rm);
				deps.def_cpsr = 1'b1;
			end
			32'b????_0001_0?00_????_????_0000_1001_????: // Swap.
			begin
				deps.use_regs = idxbit(iu.dp.rn) | idxbit(iu.dp.rm);
				deps.def_regs = idxbit(iu.dp.rd);
			end
			32'b????_0001_0010_1111_1111_1111_0001_????: // BX.
				deps.use_regs = idxbit(iu.dp.rm);
			32'b????_000?_?0??_????_????_0000_1??1_????: // Halfword with a register offset.
			begin
				deps.use_regs = idxbit(iu.dp.rn) | idxbit(iu.dp.rm) |
					(load ? '0 : idxbit(iu.dp.rd));
				deps.def_regs = (load ? idxbit(iu.dp.rd) : '0) |
					(wback ? idxbit(iu.dp.rn) : '0);
			end
			32'b????_000?_?1??_????_????_????_1??1_????: // Halfword with an immediate offset.
			begin
				deps.use_regs = idxbit(iu.dp.rn) | (load ? '0 : idxbit(iu.dp.rd));
				deps.def_regs = (load ? idxbit(iu.dp.rd) : '0) |
					(wback ? idxbit(iu.dp.rn) : '0);
			end
			32'b????_00??_????_????_????_????_????_????: // ALU.
			begin
				deps.use_cpsr = cond_matters || carry_shift;
				if (!iu.dp.i)
					deps.use_regs = idxbit(iu.dp.rm) |
						(iu.dp.shift[0] ? idxbit(iu.dp.rs) : '0);
				if ((iu.dp.opcode != arm_isa_pkg::ALU_MOV) &&
				    (iu.dp.opcode != arm_isa_pkg::ALU_MVN))
					deps.use_regs = deps.use_regs | idxbit(iu.dp.rn);
				deps.def_cpsr = iu.dp.s;
				if (!(iu.dp.opcode inside {arm_isa_pkg::ALU_TST, arm_isa_pkg::ALU_TEQ,
				                            arm_isa_pkg::ALU_CMP, arm_isa_pkg::ALU_CMN}))
					deps.def_regs = idxbit(iu.dp.rd);
			end
			32'b????_011?_????_????_????_????_???1_????: ; // Undefined reads only the condition.
			32'b????_01??_????_????_????_????_????_????: // Single data transfer.
			begin
				deps.use_regs = idxbit(iu.dp.rn) | (iu.dp.i ? idxbit(iu.dp.rm) : '0) |
					(load ? '0 : idxbit(iu.dp.rd));
				deps.def_regs = (load ? idxbit(iu.dp.rd) : '0) |
					(wback ? idxbit(iu.dp.rn) : '0);
			end
			32'b????_100?_????_????_????_????_????_????: // Block transfer.
			begin
				deps.use_regs = idxbit(iu.dp.rn) | (load ? '0 : {1'b0, insn[14:0]});
				deps.def_cpsr = insn[22]; // Covers the S bit forms that restore the CPSR.
				deps.def_regs = (insn[21] ? idxbit(iu.dp.rn) : '0) |
					(load ? {1'b0, insn[14:0]} : '0);
			end
			32'b????_101?_????_????_????_????_????_????: // Branch.
				deps.def_regs = insn[24] ? idxbit(4'(`ISSUE_LR)) : '0;
			32'b????_110?_????_????_????_????_????_????: // Coprocessor transfer.
			begin
				deps.use_regs = idxbit(iu.dp.rn);
				deps.def_regs = insn[21] ? idxbit(iu.dp.rn) : '0;
			end
			32'b????_1110_????_????_????_????_???0_????: ; // CDP reads only the condition.
			32'b????_1110_????_????_????_????_???1_????: // MRC and MCR.
			begin
				deps.use_regs = load ? '0 : idxbit(iu.dp.rd);
				deps.def_regs = load ? idxbit(iu.dp.rd) : '0;
			end
			default: ; // SWI reads nothing beyond the condition.
		endcase
	end

endmodule

/* issue/issue_scoreboard.sv */
`timescale 1ns/10ps

module issue_scoreboard #(
	parameter int DEPTH = 2
) (
	input  logic             clk,
	input  logic             Nrst,
	input  issue_pkg::deps_t deps,
	input  logic             stall_in,
	input  logic             fire,
	output logic             waiting
);

	issue_pkg::wr_entry_t pend [DEPTH]; // Entry 0 is the stage just issued into.
	issue_pkg::wr_entry_t pend_all;     // Union of every write still in flight.

	always_ff @(posedge clk or negedge Nrst)
	begin
		if (!Nrst)
		begin
			for (int i = 0; i < DEPTH; i++)
				pend[i] <= '0;
		end
		else if (!stall_in)
		begin
			pend[0] <= fire ? {deps.def_cpsr, deps.def_regs} : '0;
			for (int i = 1; i < DEPTH; i++)
				pend[i] <= pend[i-1]; // Ages one stage per advancing edge.
		end
	end

	always_comb
	begin
		pend_all = '0;
		for (int i = 0; i < DEPTH; i++)
			pend_all = pend_all | pend[i];
	end

	// Past the last entry a value comes from forwarding, so it no longer blocks.
	assign waiting = (|(deps.use_regs & pend_all.regs)) || (deps.use_cpsr && pend_all.cpsr);

endmodule

/* issue/issue_stage.sv */
`timescale 1ns/10ps

module issue_stage (
	input  logic             clk,
	input  logic             Nrst,
	input  issue_pkg::slot_t slot_in,
	input  logic             stall_in,
	input  logic             flush,
	input  logic             waiting,
	input  logic             cond_met,
	output logic             stall_out,
	output issue_pkg::slot_t slot_out,
	output logic             fire
);

	logic delayed_flush; // A flush seen while the slot could not move.
	logic kill;

	// A bubble or a flushed slot never needs to wait for its operands.
	assign stall_out = stall_in || (waiting && !slot_in.bubble && !flush);

	assign kill = slot_in.bubble || waiting || !cond_met || flush || delayed_flush;
	assign fire = !kill;

	always_ff @(posedge clk or negedge Nrst)
	begin
		if (!Nrst)
			delayed_flush <= 1'b0;
		else if (flush && stall_out)
			delayed_flush <= 1'b1;
		else if (!stall_out)
			delayed_flush <= 1'b0; // The slot that took the flush has left.
	end

	always_ff @(posedge clk or negedge Nrst)
	begin
		if (!Nrst)
		begin
			slot_out.bubble <= 1'b1;
			slot_out.pc     <= '0;
			slot_out.insn   <= '0;
		end
		else if (!stall_in)
		begin
			slot_out.bubble <= kill;
			slot_out.pc     <= slot_in.pc;
			slot_out.insn   <= slot_in.insn;
		end
	end

endmodule

/* tb.f */
+incdir+common
common/arm_isa_pkg.sv
common/issue_pkg.sv
issue/insn_deps.sv
issue/cond_eval.sv
issue/issue_scoreboard.sv
issue/issue_stage.sv
hdl/issue_top.sv
dv/tb_clkgen.sv
dv/issue_tb.sv
